//--- run.sh
#!/bin/sh
# Build and run the port arbiter testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  -f vlog.f \
  --top-module portArbiter_tb \
  -o portArbiter_sim

# Failure is judged from the log below
./obj_dir/portArbiter_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "^SIMULATION PASSED$" "$LOG"; then
  echo "Run passed"
  exit 0
else
  echo "Run failed, see $LOG"
  exit 1
fi

//--- src/arbiterFsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_defs.svh"

module arbiterFsm (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NUM_PORTS-1:0] req,
  input  logic [`NUM_PORTS-1:0] timesUp,
  output logic [`NUM_PORTS-1:0] runTimer,
  output logic [`NUM_PORTS-1:0] grant
);

  // Bit 0 is Idle, bit p+1 is port p granted
  localparam logic [`NUM_PORTS:0] IDLE_STATE = 1;

  logic [`NUM_PORTS:0] state;
  logic [`NUM_PORTS:0] nextState;

  // ####################
  // Port search
  // ####################

  // First requester among span ports, starting at port first and wrapping
  function automatic logic [`NUM_PORTS:0] pickNext(
    input logic [`NUM_PORTS-1:0] reqs,
    input int                    first,
    input int                    span
  );
    logic [`NUM_PORTS:0] pick;
    int                  idx;

    pick = IDLE_STATE;
    // Walk backwards so the earliest port in order wins
    for (int k = `NUM_PORTS - 1; k >= 0; k--)
    begin
      idx = (first + k) % `NUM_PORTS;
      if ((k < span) && reqs[idx])
      begin
        pick = '0;
        pick[idx + 1] = 1'b1;
      end
    end
    return pick;
  endfunction

  // ####################
  // State register
  // ####################

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= IDLE_STATE;
    end
    else
    begin
      state <= nextState;
    end
  end

  // ####################
  // Next state and run strobes
  // ####################

  always_comb
  begin
    nextState = IDLE_STATE;
    runTimer  = '0;

    if (!$onehot(state))
    begin
      nextState = IDLE_STATE;  // Recover from illegal encoding
    end
    else if (state[0])
    begin
      // Fixed order from Idle, Local first
      nextState = pickNext(req, int'(routerPkg::PORT_L), `NUM_PORTS);
    end
    else
    begin
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        if (state[p + 1])
        begin
          if (req[p] && !timesUp[p])
          begin
            runTimer[p] = 1'b1;  // Holder keeps the output
            nextState   = state;
          end
          else
          begin
            // Rotate from the port after the holder, holder excluded
            nextState = pickNext(req, (p + 1) % `NUM_PORTS, `NUM_PORTS - 1);
          end
        end
      end
    end
  end

  assign grant = state[`NUM_PORTS:1];  // Idle bit dropped

endmodule

`default_nettype wire

//--- src/flitMux.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_defs.svh"

module flitMux (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NUM_PORTS-1:0] grant,
  input  logic [`NUM_PORTS-1:0] req,
  input  routerPkg::flit_u      flits [`NUM_PORTS-1:0],
  output routerPkg::flit_u      outFlit,
  output logic                  outValid
);

  routerPkg::flit_u   selFlit;
  logic               selValid;

  // ####################
  // AND-OR select
  // ####################

  always_comb
  begin
    selFlit  = '0;  // Idle flit with no grant
    selValid = 1'b0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      selFlit  = selFlit | (flits[p] & {`FLIT_W{grant[p]}});
      selValid = selValid | (grant[p] & req[p]);
    end
  end

  always_ff @(posedge clk)
  begin
    outFlit <= selFlit;
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= selValid;
  end

endmodule

`default_nettype wire

//--- src/holdTimer.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_defs.svh"

module holdTimer (
  input  logic             clk,
  input  logic             rst,
  input  routerPkg::flit_u flit,
  input  logic             runTimer,
  output logic             timesUp
);

  logic [`LEN_W-1:0] limit;
  logic [`LEN_W-1:0] count;

  // ####################
  // Limit capture and hold count
  // ####################

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      // Any header updates the limit, granted or not
      if (flit.head.id == routerPkg::FLIT_HEAD)
      begin
        limit <= flit.head.len;
      end

      if (runTimer)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0;  // Fresh count for next grant
      end
    end
  end

  assign timesUp = (count == limit);

endmodule

`default_nettype wire

//--- src/portArbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_defs.svh"

module portArbiter (
  input  logic             clk,
  input  logic             rst,
  input  logic             lReq,
  input  logic             nReq,
  input  logic             eReq,
  input  logic             wReq,
  input  logic             sReq,
  input  routerPkg::flit_u lFlit,
  input  routerPkg::flit_u nFlit,
  input  routerPkg::flit_u eFlit,
  input  routerPkg::flit_u wFlit,
  input  routerPkg::flit_u sFlit,
  output logic [`NUM_PORTS-1:0] grant,
  output routerPkg::flit_u outFlit,
  output logic             outValid
);

  logic [`NUM_PORTS-1:0] req;
  logic [`NUM_PORTS-1:0] timesUp;
  logic [`NUM_PORTS-1:0] runTimer;
  routerPkg::flit_u      flits [`NUM_PORTS-1:0];

  // ####################
  // Port packing
  // ####################

  assign req[routerPkg::PORT_L] = lReq;
  assign req[routerPkg::PORT_N] = nReq;
  assign req[routerPkg::PORT_E] = eReq;
  assign req[routerPkg::PORT_W] = wReq;
  assign req[routerPkg::PORT_S] = sReq;

  assign flits[routerPkg::PORT_L] = lFlit;
  assign flits[routerPkg::PORT_N] = nFlit;
  assign flits[routerPkg::PORT_E] = eFlit;
  assign flits[routerPkg::PORT_W] = wFlit;
  assign flits[routerPkg::PORT_S] = sFlit;

  // One hold timer per input port
  holdTimer lTimer (
    .clk, .rst, .flit(lFlit),
    .runTimer(runTimer[routerPkg::PORT_L]),
    .timesUp(timesUp[routerPkg::PORT_L])
  );
  holdTimer nTimer (
    .clk, .rst, .flit(nFlit),
    .runTimer(runTimer[routerPkg::PORT_N]),
    .timesUp(timesUp[routerPkg::PORT_N])
  );
  holdTimer eTimer (
    .clk, .rst, .flit(eFlit),
    .runTimer(runTimer[routerPkg::PORT_E]),
    .timesUp(timesUp[routerPkg::PORT_E])
  );
  holdTimer wTimer (
    .clk, .rst, .flit(wFlit),
    .runTimer(runTimer[routerPkg::PORT_W]),
    .timesUp(timesUp[routerPkg::PORT_W])
  );
  holdTimer sTimer (
    .clk, .rst, .flit(sFlit),
    .runTimer(runTimer[routerPkg::PORT_S]),
    .timesUp(timesUp[routerPkg::PORT_S])
  );

  arbiterFsm fsm (
    .clk, .rst, .req, .timesUp, .runTimer, .grant
  );

  flitMux mux (
    .clk, .rst, .grant, .req, .flits, .outFlit, .outValid  // Output one cycle behind grant
  );

endmodule

`default_nettype wire

//--- src/routerPkg.sv
`default_nettype none

`include "router_defs.svh"

package routerPkg;

  typedef enum logic [2:0] {
    FLIT_IDLE = 3'd0,
    FLIT_HEAD = 3'd1,
    FLIT_BODY = 3'd2,
    FLIT_TAIL = 3'd3
  } flitId_e;

  // ####################
  // Flit word views
  // ####################

  typedef struct packed {
    flitId_e           id;
    logic              spare;
    logic [`LEN_W-1:0] len;  // Packet length, also the hold limit
  } headFlit_t;

  typedef struct packed {
    flitId_e            id;
    logic [`FLIT_W-4:0] payload;
  } bodyFlit_t;

  typedef union packed {
    headFlit_t head;
    bodyFlit_t body;
  } flit_u;

  // Bit positions in grant and run vectors
  typedef enum logic [2:0] {PORT_L, PORT_N, PORT_E, PORT_W, PORT_S} portIdx_e;

endpackage

`default_nettype wire

//--- src/router_defs.svh
`ifndef ROUTER_DEFS_SVH
`define ROUTER_DEFS_SVH

// ####################
// Router geometry
// ####################

`define NUM_PORTS 5  // Local, North, East, West, South

`define FLIT_W 16  // One flit word
`define LEN_W 12  // Header length field and hold counter

`endif

//--- verif/portArbiter_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_defs.svh"

module portArbiter_chk (
  input logic                  clk,
  input logic                  rst,
  input logic [`NUM_PORTS-1:0] grant,
  input logic                  outValid
);

  // ####################
  // Grant invariants
  // ####################

  // At most one port owns the output
  grantOneHot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(grant)
  )
  else $error("grant %b has more than one bit set", grant);

  // Valid output only from a cycle with a holder
  validNeedsGrant: assert property (
    @(posedge clk) disable iff (rst)
    outValid |-> ($past(grant) != '0)
  )
  else $error("outValid high after a cycle with no grant");

  // ####################
  // Reset
  // ####################

  grantClearAfterReset: assert property (
    @(posedge clk)
    rst |=> (grant == '0)
  )
  else $error("grant %b not cleared after reset", grant);

endmodule

`default_nettype wire

//--- verif/portArbiter_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_defs.svh"

module portArbiter_tb;

  localparam int CLK_PERIOD   = 40;
  localparam int NUM_CYCLES   = 3000;
  localparam int RESET_CYCLES = 2;
  localparam int TIMEOUT_NS   = (NUM_CYCLES + 100) * CLK_PERIOD;  // Run length plus margin

  logic                  clk;
  logic                  rst;
  logic [`NUM_PORTS-1:0] reqIn;
  routerPkg::flit_u      flitIn [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] grant;
  routerPkg::flit_u      outFlit;
  logic                  outValid;

  logic [31:0] lfsr;

  // Model state, 0 is Idle and p+1 means port p holds the output
  int                mState;
  logic [`LEN_W-1:0] mLimit [`NUM_PORTS];
  logic [`LEN_W-1:0] mCount [`NUM_PORTS];
  routerPkg::flit_u  mOutFlit;
  logic              mOutValid;

  int grantCount [`NUM_PORTS];  // Coverage counters
  int expiryCount;
  int dropCount;
  int handoverCount;
  int contestCount;

  portArbiter portArbiter_inst (
    .clk,
    .rst,
    .lReq(reqIn[routerPkg::PORT_L]),
    .nReq(reqIn[routerPkg::PORT_N]),
    .eReq(reqIn[routerPkg::PORT_E]),
    .wReq(reqIn[routerPkg::PORT_W]),
    .sReq(reqIn[routerPkg::PORT_S]),
    .lFlit(flitIn[routerPkg::PORT_L]),
    .nFlit(flitIn[routerPkg::PORT_N]),
    .eFlit(flitIn[routerPkg::PORT_E]),
    .wFlit(flitIn[routerPkg::PORT_W]),
    .sFlit(flitIn[routerPkg::PORT_S]),
    .grant,
    .outFlit,
    .outValid
  );

  bind portArbiter portArbiter_chk chk (
    .clk(clk), .rst(rst), .grant(grant), .outValid(outValid)
  );

  // ####################
  // Clock and watchdog
  // ####################

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, the test loop never finished", TIMEOUT_NS);
    stopRun();
  end

  // ####################
  // Random source
  // ####################

  // Fibonacci LFSR with taps 32, 22, 2, 1, one step per bit
  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic routerPkg::flit_u makeFlit();
    routerPkg::flit_u f;
    logic [31:0]      bits;
    f = '0;
    if (takeBits(2) == 32'd3)
    begin
      bits       = takeBits(3);  // Header in one case of four
      f.head.id  = routerPkg::FLIT_HEAD;
      f.head.len = bits[`LEN_W-1:0];
    end
    else
    begin
      bits           = takeBits(`FLIT_W - 3);
      f.body.id      = routerPkg::FLIT_BODY;
      f.body.payload = bits[`FLIT_W-4:0];
    end
    return f;
  endfunction

  task automatic driveInputs();
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      reqIn[p]  <= (takeBits(2) != 32'd0);  // High three times in four
      flitIn[p] <= makeFlit();
    end
  endtask

  // ####################
  // Reference model
  // ####################

  function automatic logic [`NUM_PORTS-1:0] grantFor(input int st);
    logic [`NUM_PORTS-1:0] g;
    g = '0;
    if (st != 0)
      g[st - 1] = 1'b1;
    return g;
  endfunction

  // One clock edge of timers, arbiter and output register
  task automatic modelStep();
    logic [`NUM_PORTS-1:0] run;
    int                    nextSt;
    int                    holder;
    int                    cand;
    run    = '0;
    nextSt = 0;
    if (mState == 0)
    begin
      if ($countones(reqIn) > 1)
        contestCount++;
      for (int p = 0; p < `NUM_PORTS; p++)
        if (nextSt == 0 && reqIn[p])
          nextSt = p + 1;
      mOutFlit  = '0;
      mOutValid = 1'b0;
    end
    else
    begin
      holder    = mState - 1;
      mOutFlit  = flitIn[holder];
      mOutValid = reqIn[holder];
      if (reqIn[holder] && mCount[holder] != mLimit[holder])
      begin
        run[holder] = 1'b1;
        nextSt      = mState;
      end
      else
      begin
        if (reqIn[holder])
          expiryCount++;
        else
          dropCount++;
        for (int k = 1; k < `NUM_PORTS; k++)
        begin
          cand = (holder + k) % `NUM_PORTS;
          if (nextSt == 0 && reqIn[cand])
            nextSt = cand + 1;
        end
        if (nextSt != 0)
          handoverCount++;
      end
    end

    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (flitIn[p].head.id == routerPkg::FLIT_HEAD)
        mLimit[p] = flitIn[p].head.len;
      mCount[p] = run[p] ? mCount[p] + 1'b1 : '0;
    end

    if (nextSt != 0 && nextSt != mState)
      grantCount[nextSt - 1]++;
    mState = nextSt;
  endtask

  // ####################
  // Checks
  // ####################

  task automatic stopRun();
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      stopRun();
    end
  endtask

  function automatic bit coverageMet();
    bit ok;
    ok = (expiryCount > 0) && (dropCount > 0) && (handoverCount > 0) && (contestCount > 0);
    for (int p = 0; p < `NUM_PORTS; p++)
      ok = ok && (grantCount[p] > 0);
    return ok;
  endfunction

  initial
  begin
    lfsr      = 32'h1481;
    mState    = 0;
    mOutFlit  = '0;
    mOutValid = 1'b0;
    expiryCount   = 0;
    dropCount     = 0;
    handoverCount = 0;
    contestCount  = 0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      mLimit[p]     = '0;
      mCount[p]     = '0;
      grantCount[p] = 0;
      flitIn[p]    <= '0;
    end
    rst   <= 1'b1;
    reqIn <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;

    for (int c = 0; c < NUM_CYCLES; c++)
    begin
      @(posedge clk);
      modelStep();  // Sees the inputs this edge samples
      driveInputs();
      @(negedge clk);
      checkValue("grant", 32'(grant), 32'(grantFor(mState)));
      checkValue("outFlit", 32'(outFlit), 32'(mOutFlit));
      checkValue("outValid", 32'(outValid), 32'(mOutValid));
    end

    $display("Grants L/N/E/W/S: %0d %0d %0d %0d %0d, expiries %0d, drops %0d, handovers %0d",
      grantCount[0], grantCount[1], grantCount[2], grantCount[3], grantCount[4],
      expiryCount, dropCount, handoverCount);
    if (coverageMet())
    begin
      $display("SIMULATION PASSED");
      $finish;
    end
    else
    begin
      $display("Random stimulus missed a port or a release case, see the counts above");
      stopRun();
    end
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+src
src/routerPkg.sv
src/holdTimer.sv
src/arbiterFsm.sv
src/flitMux.sv
src/portArbiter.sv
verif/portArbiter_chk.sv
verif/portArbiter_tb.sv
